//--- source/capture_ifs.sv
// Bundles used between the capture blocks
// Register bus page, DMA control/status and the packed beat stream
`timescale 1ns/100ps
`default_nettype none

interface wb_bus_if import capture_pkg::*; ();
    logic [WB_ADR_W-1:0]    adr;
    wb_data_t               dat_w;
    wb_data_t               dat_r;
    logic                   we;
    logic [WB_DAT_W/8-1:0]  sel;
    logic                   stb;    // already page qualified
    logic                   ack;

    modport master (output adr, dat_w, we, sel, stb, input dat_r, ack);
    modport slave  (input adr, dat_w, we, sel, stb, output dat_r, ack);
endinterface

interface dma_ctrl_if import capture_pkg::*; ();
    logic       enable;
    addr_t      base;
    dim_t       width;
    dim_t       height;
    awlen_t     awlen;
    logic       busy;
    logic       frame_done;     // one cycle pulse

    modport regs   (output enable, base, width, height, awlen, input busy, frame_done);
    modport writer (input enable, base, width, height, awlen, output busy, frame_done);
endinterface

interface pixel_beat_if import capture_pkg::*; ();
    beat_t      data;
    logic       first;          // first pixel carried tuser
    logic       valid;
    logic       ready;

    modport source (output data, first, valid, input ready);
    modport sink   (input data, first, valid, output ready);
endinterface

`default_nettype wire

//--- source/capture_pkg.sv
// Capture path shared definitions
// Peripheral bus address map, DMA register offsets, pixel and memory
// widths, and the payload types used across the design
`default_nettype none

package capture_pkg;

    // peripheral bus
    localparam int WB_ADR_W = 30;           // word address
    localparam int WB_DAT_W = 32;

    localparam logic [19:0] PAGE_GID  = 20'h40000;
    localparam logic [19:0] PAGE_DMA  = 20'h40010;
    localparam logic [31:0] GLOBAL_ID = 32'h01234567;

    // DMA page, word offsets
    localparam int REG_CTRL   = 0;          // bit 0 enable
    localparam int REG_STATUS = 1;          // bit 0 busy
    localparam int REG_FRAMES = 2;
    localparam int REG_BASE   = 4;
    localparam int REG_WIDTH  = 5;
    localparam int REG_HEIGHT = 6;
    localparam int REG_AWLEN  = 7;

    // pixel stream and memory side
    localparam int RGB_W      = 40;
    localparam int COMP_W     = 10;
    localparam int PIX_W      = 32;
    localparam int BEAT_W     = 64;
    localparam int BEAT_BYTES = 8;
    localparam int ADDR_W     = 32;
    localparam int DIM_W      = 14;
    localparam int AWLEN_W    = 8;

    typedef logic [WB_DAT_W-1:0] wb_data_t;
    typedef logic [RGB_W-1:0]    rgb_t;
    typedef logic [BEAT_W-1:0]   beat_t;
    typedef logic [ADDR_W-1:0]   addr_t;
    typedef logic [DIM_W-1:0]    dim_t;
    typedef logic [AWLEN_W-1:0]  awlen_t;

endpackage

`default_nettype wire

//--- source/dma_frame_writer.sv
// Frame writer
// Waits for a frame start beat, then writes the frame to memory as
// AXI4 INCR bursts of awlen+1 beats and counts the write responses
`timescale 1ns/100ps
`default_nettype none

module dma_frame_writer import capture_pkg::*; (
    input  wire logic       axi4_mem_aclk,
    input  wire logic       rst_n_i,
    pixel_beat_if.sink      beat,
    dma_ctrl_if.writer      ctrl,
    output addr_t           m_awaddr_o,
    output awlen_t          m_awlen_o,
    output logic            m_awvalid_o,
    input  wire logic       m_awready_i,
    output beat_t           m_wdata_o,
    output logic            m_wlast_o,
    output logic            m_wvalid_o,
    input  wire logic       m_wready_i,
    input  wire logic       m_bvalid_i,
    input  wire logic [1:0] m_bresp_i,      // every response counts, code not examined
    output logic            m_bready_o
);

    typedef enum logic [1:0] {ST_IDLE, ST_AW, ST_W, ST_RESP} state_t;

    state_t             state_q;
    addr_t              addr_q;
    awlen_t             awlen_q;
    awlen_t             wcnt_q;
    logic [2*DIM_W-1:0] beats_left_q;
    logic [2*DIM_W-1:0] aw_cnt_q;
    logic [2*DIM_W-1:0] b_cnt_q;
    logic               frame_start;
    logic               w_fire;

    assign frame_start = (state_q == ST_IDLE) && beat.valid && beat.first && ctrl.enable;
    assign w_fire      = m_wvalid_o && m_wready_i;

    // idle drops beats, but holds the frame start beat
    assign beat.ready = (state_q == ST_IDLE) ? !(beat.first && ctrl.enable) :
                        (state_q == ST_W)    ? m_wready_i : 1'b0;

    assign m_awaddr_o  = addr_q;
    assign m_awlen_o   = awlen_q;
    assign m_awvalid_o = (state_q == ST_AW);
    assign m_wdata_o   = beat.data;
    assign m_wvalid_o  = (state_q == ST_W) && beat.valid;
    assign m_wlast_o   = (wcnt_q == awlen_q);
    assign m_bready_o  = 1'b1;

    assign ctrl.busy       = (state_q != ST_IDLE);
    assign ctrl.frame_done = (state_q == ST_RESP) && (b_cnt_q == aw_cnt_q);

    // ------------------------------------------------------------------------
    //  burst sequencing
    // ------------------------------------------------------------------------

    always_ff @(posedge axi4_mem_aclk) begin
        if (!rst_n_i) begin
            state_q      <= ST_IDLE;
            wcnt_q       <= '0;
            beats_left_q <= '0;
            aw_cnt_q     <= '0;
            b_cnt_q      <= '0;
        end else begin
            if (m_bvalid_i && m_bready_o && state_q != ST_IDLE) begin
                b_cnt_q <= b_cnt_q + 1'b1;
            end
            case (state_q)
                ST_IDLE: begin
                    if (frame_start) begin
                        beats_left_q <= ((2*DIM_W)'(ctrl.width) * ctrl.height) >> 1;
                        aw_cnt_q     <= '0;
                        b_cnt_q      <= '0;
                        state_q      <= ST_AW;
                    end
                end
                ST_AW: begin
                    if (m_awready_i) begin
                        aw_cnt_q <= aw_cnt_q + 1'b1;
                        wcnt_q   <= '0;
                        state_q  <= ST_W;
                    end
                end
                ST_W: begin
                    if (w_fire) begin
                        wcnt_q       <= wcnt_q + 1'b1;
                        beats_left_q <= beats_left_q - 1'b1;
                        if (m_wlast_o) begin
                            state_q <= (beats_left_q == 1) ? ST_RESP : ST_AW;
                        end
                    end
                end
                ST_RESP: begin
                    if (ctrl.frame_done) begin      // all bursts answered
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // frame config and burst address
    always_ff @(posedge axi4_mem_aclk) begin
        if (frame_start) begin
            addr_q  <= ctrl.base;
            awlen_q <= ctrl.awlen;
        end else if (w_fire && m_wlast_o) begin
            addr_q <= addr_q + (addr_t'(awlen_q) + 1'b1) * BEAT_BYTES;
        end
    end

endmodule

`default_nettype wire

//--- source/dma_regs.sv
// DMA register page
// Enable, base address, frame size and burst length for the frame
// writer, plus busy status and a completed frame counter
`timescale 1ns/100ps
`default_nettype none

module dma_regs import capture_pkg::*; (
    input  wire logic   axi4_mem_aclk,
    input  wire logic   rst_n_i,
    wb_bus_if.slave     bus,
    dma_ctrl_if.regs    ctrl
);

    logic       enable_q;
    addr_t      base_q;
    dim_t       width_q;
    dim_t       height_q;
    awlen_t     awlen_q;
    wb_data_t   frames_q;
    wb_data_t   rd_data;
    wb_data_t   wr_mask;
    wb_data_t   wr_data;
    logic       wr_en;

    always_comb begin
        case (bus.adr[9:0])
            REG_CTRL:   rd_data = wb_data_t'(enable_q);
            REG_STATUS: rd_data = wb_data_t'(ctrl.busy);
            REG_FRAMES: rd_data = frames_q;
            REG_BASE:   rd_data = wb_data_t'(base_q);
            REG_WIDTH:  rd_data = wb_data_t'(width_q);
            REG_HEIGHT: rd_data = wb_data_t'(height_q);
            REG_AWLEN:  rd_data = wb_data_t'(awlen_q);
            default:    rd_data = '0;
        endcase
    end

    // byte lanes not selected keep their old value
    always_comb begin
        for (int i = 0; i < WB_DAT_W / 8; i++) begin
            wr_mask[i*8 +: 8] = {8{bus.sel[i]}};
        end
    end

    assign wr_data   = (rd_data & ~wr_mask) | (bus.dat_w & wr_mask);
    assign wr_en     = bus.stb && bus.we;
    assign bus.dat_r = rd_data;
    assign bus.ack   = bus.stb;     // zero wait

    always_ff @(posedge axi4_mem_aclk) begin
        if (!rst_n_i) begin
            enable_q <= 1'b0;
            base_q   <= '0;
            width_q  <= '0;
            height_q <= '0;
            awlen_q  <= '0;
            frames_q <= '0;
        end else begin
            if (wr_en) begin
                case (bus.adr[9:0])
                    REG_CTRL:   enable_q <= wr_data[0];
                    REG_BASE:   base_q   <= wr_data[ADDR_W-1:0];
                    REG_WIDTH:  width_q  <= wr_data[DIM_W-1:0];
                    REG_HEIGHT: height_q <= wr_data[DIM_W-1:0];
                    REG_AWLEN:  awlen_q  <= wr_data[AWLEN_W-1:0];
                    default: ;              // status and frames read only
                endcase
            end
            if (ctrl.frame_done) begin
                frames_q <= frames_q + 1'b1;
            end
        end
    end

    assign ctrl.enable = enable_q;
    assign ctrl.base   = base_q;
    assign ctrl.width  = width_q;
    assign ctrl.height = height_q;
    assign ctrl.awlen  = awlen_q;

endmodule

`default_nettype wire

//--- source/pixel_packer.sv
// RGB pixel packer
// Keeps the upper 8 bits of each 10-bit component and pairs pixels
// into 64-bit beats, even pixel in the low half
`timescale 1ns/100ps
`default_nettype none

module pixel_packer import capture_pkg::*; (
    input  wire logic   axi4_mem_aclk,
    input  wire logic   rst_n_i,
    input  wire logic   s_tuser_i,
    input  wire logic   s_tlast_i,      // line ends follow from the width
    input  wire logic   s_tvalid_i,
    input  wire rgb_t   s_tdata_i,
    output logic        s_tready_o,
    output logic        frame_toggle_o,
    pixel_beat_if.source beat
);

    logic [PIX_W-1:0]   pix;
    logic [PIX_W-1:0]   lo_q;
    logic               lo_full_q;
    logic               lo_first_q;
    beat_t              data_q;
    logic               first_q;
    logic               valid_q;
    logic               accept;
    logic               pair_done;

    function automatic logic [PIX_W-1:0] cut_pixel(rgb_t d);
        logic [PIX_W-1:0] p;
        for (int c = 0; c < RGB_W / COMP_W; c++) begin
            p[c*(PIX_W/(RGB_W/COMP_W)) +: PIX_W/(RGB_W/COMP_W)] =
                d[(c+1)*COMP_W - PIX_W/(RGB_W/COMP_W) +: PIX_W/(RGB_W/COMP_W)];
        end
        return p;
    endfunction

    assign pix        = cut_pixel(s_tdata_i);
    assign s_tready_o = !valid_q || beat.ready;    // one beat of storage
    assign accept     = s_tvalid_i && s_tready_o;
    assign pair_done  = accept && !s_tuser_i && lo_full_q;

    always_ff @(posedge axi4_mem_aclk) begin
        if (!rst_n_i) begin
            lo_full_q      <= 1'b0;
            valid_q        <= 1'b0;
            frame_toggle_o <= 1'b0;
        end else begin
            if (valid_q && beat.ready) begin
                valid_q <= 1'b0;
            end
            if (accept) begin
                lo_full_q <= !pair_done;   // tuser restarts the pair
                if (s_tuser_i) begin
                    frame_toggle_o <= !frame_toggle_o;
                end
            end
            if (pair_done) begin
                valid_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge axi4_mem_aclk) begin
        if (pair_done) begin
            data_q  <= {pix, lo_q};
            first_q <= lo_first_q;
        end else if (accept) begin
            lo_q       <= pix;
            lo_first_q <= s_tuser_i;
        end
    end

    assign beat.data  = data_q;
    assign beat.first = first_q;
    assign beat.valid = valid_q;

endmodule

`default_nettype wire

//--- source/video_capture_top.sv
// Video capture top level
// RGB pixel stream to memory through AXI4 write bursts, set up over
// the peripheral register bus
`timescale 1ns/100ps
`default_nettype none

module video_capture_top import capture_pkg::*; (
    input  wire logic                   axi4_mem_aclk,
    input  wire logic                   rst_n_i,

    // register bus
    input  wire logic [WB_ADR_W-1:0]    wb_adr_i,
    input  wire wb_data_t               wb_dat_i,
    input  wire logic [WB_DAT_W/8-1:0]  wb_sel_i,
    input  wire logic                   wb_we_i,
    input  wire logic                   wb_stb_i,
    output wb_data_t                    wb_dat_o,
    output logic                        wb_ack_o,

    // pixel stream
    input  wire logic                   s_tuser_i,
    input  wire logic                   s_tlast_i,
    input  wire logic                   s_tvalid_i,
    input  wire rgb_t                   s_tdata_i,
    output logic                        s_tready_o,
    output logic                        frame_toggle_o,

    // AXI4 write
    output addr_t                       m_awaddr_o,
    output awlen_t                      m_awlen_o,
    output logic                        m_awvalid_o,
    input  wire logic                   m_awready_i,
    output beat_t                       m_wdata_o,
    output logic                        m_wlast_o,
    output logic                        m_wvalid_o,
    input  wire logic                   m_wready_i,
    input  wire logic                   m_bvalid_i,
    input  wire logic [1:0]             m_bresp_i,
    output logic                        m_bready_o
);

    wb_bus_if       dma_bus ();
    dma_ctrl_if     dma_ctrl ();
    pixel_beat_if   beat ();

    // ------------------------------------------------------------------------
    //  register bus
    // ------------------------------------------------------------------------

    wb_decoder u_wb_decoder (
        .axi4_mem_aclk  (axi4_mem_aclk),
        .rst_n_i        (rst_n_i),
        .wb_adr_i       (wb_adr_i),
        .wb_dat_i       (wb_dat_i),
        .wb_sel_i       (wb_sel_i),
        .wb_we_i        (wb_we_i),
        .wb_stb_i       (wb_stb_i),
        .wb_dat_o       (wb_dat_o),
        .wb_ack_o       (wb_ack_o),
        .dma_bus        (dma_bus)
    );

    dma_regs u_dma_regs (
        .axi4_mem_aclk  (axi4_mem_aclk),
        .rst_n_i        (rst_n_i),
        .bus            (dma_bus),
        .ctrl           (dma_ctrl)
    );

    // ------------------------------------------------------------------------
    //  pixel path
    // ------------------------------------------------------------------------

    pixel_packer u_pixel_packer (
        .axi4_mem_aclk  (axi4_mem_aclk),
        .rst_n_i        (rst_n_i),
        .s_tuser_i      (s_tuser_i),
        .s_tlast_i      (s_tlast_i),
        .s_tvalid_i     (s_tvalid_i),
        .s_tdata_i      (s_tdata_i),
        .s_tready_o     (s_tready_o),
        .frame_toggle_o (frame_toggle_o),
        .beat           (beat)
    );

    dma_frame_writer u_dma_frame_writer (
        .axi4_mem_aclk  (axi4_mem_aclk),
        .rst_n_i        (rst_n_i),
        .beat           (beat),
        .ctrl           (dma_ctrl),
        .m_awaddr_o     (m_awaddr_o),
        .m_awlen_o      (m_awlen_o),
        .m_awvalid_o    (m_awvalid_o),
        .m_awready_i    (m_awready_i),
        .m_wdata_o      (m_wdata_o),
        .m_wlast_o      (m_wlast_o),
        .m_wvalid_o     (m_wvalid_o),
        .m_wready_i     (m_wready_i),
        .m_bvalid_i     (m_bvalid_i),
        .m_bresp_i      (m_bresp_i),
        .m_bready_o     (m_bready_o)
    );

endmodule

`default_nettype wire

//--- source/wb_decoder.sv
// Peripheral bus page decoder
// Answers the global ID page, forwards the DMA page and acks
// unmapped pages with zero data so the bus never stalls
`timescale 1ns/100ps
`default_nettype none

module wb_decoder import capture_pkg::*; (
    input  wire logic                   axi4_mem_aclk,
    input  wire logic                   rst_n_i,
    input  wire logic [WB_ADR_W-1:0]    wb_adr_i,
    input  wire wb_data_t               wb_dat_i,
    input  wire logic [WB_DAT_W/8-1:0]  wb_sel_i,
    input  wire logic                   wb_we_i,
    input  wire logic                   wb_stb_i,
    output wb_data_t                    wb_dat_o,
    output logic                        wb_ack_o,
    wb_bus_if.master                    dma_bus
);

    logic       gid_hit;
    logic       dma_hit;

    assign gid_hit = wb_stb_i && (wb_adr_i[WB_ADR_W-1:10] == PAGE_GID);
    assign dma_hit = wb_stb_i && (wb_adr_i[WB_ADR_W-1:10] == PAGE_DMA);

    assign dma_bus.adr   = wb_adr_i;
    assign dma_bus.dat_w = wb_dat_i;
    assign dma_bus.we    = wb_we_i;
    assign dma_bus.sel   = wb_sel_i;
    assign dma_bus.stb   = dma_hit;

    always_comb begin
        if (gid_hit) begin
            wb_dat_o = GLOBAL_ID;
            wb_ack_o = wb_stb_i;
        end else if (dma_hit) begin
            wb_dat_o = dma_bus.dat_r;
            wb_ack_o = dma_bus.ack;
        end else begin
            wb_dat_o = '0;                  // unmapped
            wb_ack_o = wb_stb_i;
        end
    end

endmodule

`default_nettype wire

//--- src.f
source/capture_pkg.sv
source/capture_ifs.sv
source/wb_decoder.sv
source/dma_regs.sv
source/pixel_packer.sv
source/dma_frame_writer.sv
source/video_capture_top.sv
test/video_capture_asserts.sv
test/tb_video_capture.sv

//--- test/tb_video_capture.sv
// Testbench for the video capture path
// Register bus checks, then random frames through the packer and the
// frame writer, compared with a reference model and an AXI4 memory model
`timescale 1ns/100ps
`default_nettype none

module tb_video_capture import capture_pkg::*; ();

    localparam int NUM_FRAMES      = 4;
    localparam int MAX_FRAME_BEATS = 60;    // width 24, height 5
    localparam int TEST_BEATS      = NUM_FRAMES * (MAX_FRAME_BEATS + 8) + 8;
    localparam int TIMEOUT_CYCLES  = TEST_BEATS * 40 + 2000;

    logic                   axi4_mem_aclk;
    logic                   rst_n_i;
    logic [WB_ADR_W-1:0]    wb_adr_i;
    wb_data_t               wb_dat_i;
    logic [WB_DAT_W/8-1:0]  wb_sel_i;
    logic                   wb_we_i;
    logic                   wb_stb_i;
    wb_data_t               wb_dat_o;
    logic                   wb_ack_o;
    logic                   s_tuser_i;
    logic                   s_tlast_i;
    logic                   s_tvalid_i;
    rgb_t                   s_tdata_i;
    logic                   s_tready_o;
    logic                   frame_toggle_o;
    addr_t                  m_awaddr_o;
    awlen_t                 m_awlen_o;
    logic                   m_awvalid_o;
    logic                   m_awready_i;
    beat_t                  m_wdata_o;
    logic                   m_wlast_o;
    logic                   m_wvalid_o;
    logic                   m_wready_i;
    logic                   m_bvalid_i;
    logic [1:0]             m_bresp_i;
    logic                   m_bready_o;

    // reference model state
    beat_t              exp_beats[$];
    addr_t              exp_addrs[$];
    awlen_t             exp_awlen;
    logic               enable_m;
    logic               toggle_m;
    logic [PIX_W-1:0]   lo_m;
    logic               lo_full_m;
    logic               lo_first_m;
    int                 frame_beats_m;
    int                 frame_left_m;
    int                 frames_m;
    // memory model state
    int                 pending_b;
    int                 burst_beat;
    logic               burst_open;
    int                 errors;

    video_capture_top DUT (.*);

    initial begin : clock_gen
        axi4_mem_aclk = 1'b0;
        forever #4 axi4_mem_aclk = ~axi4_mem_aclk;
    end

    initial begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge axi4_mem_aclk);
        $display("watchdog expired, the test did not finish in %0d cycles", TIMEOUT_CYCLES);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped by the watchdog");
    end

    // ------------------------------------------------------------------------
    //  checks
    // ------------------------------------------------------------------------

    task automatic stop_on_error(input string what);
        errors++;
        $display("%s", what);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_word(input string name, input wb_data_t got, input wb_data_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("error at %0t ns: %s is %h, expected %h",
                                    $time, name, got, exp));
        end
    endtask

    task automatic check_beat(input string name, input beat_t got, input beat_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("error at %0t ns: %s is %h, expected %h",
                                    $time, name, got, exp));
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("error at %0t ns: %s is %h, expected %h",
                                    $time, name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_on_error($sformatf("error at %0t ns: %s is %b, expected %b",
                                    $time, name, got, exp));
        end
    endtask

    // ------------------------------------------------------------------------
    //  reference model
    // ------------------------------------------------------------------------

    // upper 8 bits of each 10-bit component, component 0 lowest
    function automatic logic [PIX_W-1:0] truncate_pixel(input rgb_t d);
        return {d[39:32], d[29:22], d[19:12], d[9:2]};
    endfunction

    task automatic model_beat(input beat_t b, input logic first);
        if (frame_left_m == 0 && first && enable_m) begin
            frame_left_m = frame_beats_m;
        end
        if (frame_left_m > 0) begin
            exp_beats.push_back(b);
            frame_left_m--;
        end
    endtask

    task automatic model_pixel(input rgb_t d, input logic user);
        if (user) begin
            toggle_m = !toggle_m;
        end
        if (user || !lo_full_m) begin       // tuser drops a half pair
            lo_m       = truncate_pixel(d);
            lo_first_m = user;
            lo_full_m  = 1'b1;
        end else begin
            lo_full_m = 1'b0;
            model_beat({truncate_pixel(d), lo_m}, lo_first_m);
        end
    endtask

    // ------------------------------------------------------------------------
    //  memory model
    // ------------------------------------------------------------------------

    task automatic accept_aw();
        if (burst_open) begin
            stop_on_error("AW issued before the last W beat of the previous burst");
        end else if (exp_addrs.size() == 0) begin
            stop_on_error("AW burst that the reference model does not expect");
        end else begin
            check_addr("m_awaddr_o", m_awaddr_o, exp_addrs.pop_front());
            check_word("m_awlen_o", wb_data_t'(m_awlen_o), wb_data_t'(exp_awlen));
            burst_open = 1'b1;
            burst_beat = 0;
        end
    endtask

    task automatic accept_w();
        if (!burst_open) begin
            stop_on_error("W beat sent outside of an AW burst");
        end else if (exp_beats.size() == 0) begin
            stop_on_error("W beat that the reference model does not expect");
        end else begin
            check_beat("m_wdata_o", m_wdata_o, exp_beats.pop_front());
            check_bit("m_wlast_o", m_wlast_o, burst_beat == int'(exp_awlen));
            if (m_wlast_o) begin
                burst_open = 1'b0;
                pending_b++;
            end else begin
                burst_beat++;
            end
        end
    endtask

    initial begin : memory_model
        m_awready_i = 1'b0;
        m_wready_i  = 1'b0;
        m_bvalid_i  = 1'b0;
        m_bresp_i   = 2'b00;
        wait (rst_n_i === 1'b1);
        forever begin
            @(negedge axi4_mem_aclk);
            if (m_awvalid_o && m_awready_i) begin
                accept_aw();
            end
            if (m_wvalid_o && m_wready_i) begin
                accept_w();
            end
            if (m_bvalid_i && m_bready_o) begin
                pending_b--;
            end
            @(posedge axi4_mem_aclk);
            #1;
            m_awready_i = ($urandom_range(0, 2) != 0);
            m_wready_i  = ($urandom_range(0, 2) != 0);
            m_bvalid_i  = (pending_b > 0);  // one response per burst
        end
    end

    // ------------------------------------------------------------------------
    //  bus and stream drivers
    // ------------------------------------------------------------------------

    task automatic bus_access(input logic [WB_ADR_W-1:0] adr, input logic we,
                              input wb_data_t wdata, output wb_data_t rdata);
        @(posedge axi4_mem_aclk);
        #1;
        wb_adr_i = adr;
        wb_we_i  = we;
        wb_dat_i = wdata;
        wb_sel_i = '1;
        wb_stb_i = 1'b1;
        @(negedge axi4_mem_aclk);
        check_bit("wb_ack_o", wb_ack_o, 1'b1);     // zero wait ack
        rdata = wb_dat_o;
        @(posedge axi4_mem_aclk);
        #1;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
    endtask

    task automatic reg_write(input int off, input wb_data_t val);
        wb_data_t unused;
        bus_access({PAGE_DMA, 10'(off)}, 1'b1, val, unused);
    endtask

    task automatic reg_read(input int off, output wb_data_t val);
        bus_access({PAGE_DMA, 10'(off)}, 1'b0, '0, val);
    endtask

    task automatic send_pixel(input rgb_t d, input logic user, input logic last);
        int gap;
        gap = ($urandom_range(0, 3) == 0) ? $urandom_range(1, 3) : 0;
        repeat (gap) begin
            @(posedge axi4_mem_aclk);
            #1;
            s_tvalid_i = 1'b0;
        end
        @(posedge axi4_mem_aclk);
        #1;
        s_tvalid_i = 1'b1;
        s_tdata_i  = d;
        s_tuser_i  = user;
        s_tlast_i  = last;
        @(negedge axi4_mem_aclk);
        while (!s_tready_o) begin
            @(negedge axi4_mem_aclk);
        end
        model_pixel(d, user);
    endtask

    task automatic stream_idle();
        @(posedge axi4_mem_aclk);
        #1;
        s_tvalid_i = 1'b0;
        s_tuser_i  = 1'b0;
        s_tlast_i  = 1'b0;
    endtask

    // ------------------------------------------------------------------------
    //  tests
    // ------------------------------------------------------------------------

    task automatic test_registers();
        int             offs[5];
        wb_data_t       masks[5];
        wb_data_t       vals[5];
        wb_data_t       rdata;
        logic [19:0]    page;
        offs  = '{REG_BASE, REG_WIDTH, REG_HEIGHT, REG_AWLEN, REG_CTRL};
        masks = '{wb_data_t'({ADDR_W{1'b1}}), wb_data_t'({DIM_W{1'b1}}),
                  wb_data_t'({DIM_W{1'b1}}), wb_data_t'({AWLEN_W{1'b1}}), wb_data_t'(1)};
        bus_access({PAGE_GID, 10'($urandom())}, 1'b0, '0, rdata);
        check_word("wb_dat_o (id page)", rdata, GLOBAL_ID);
        for (int i = 0; i < 5; i++) begin
            vals[i] = wb_data_t'($urandom());
            reg_write(offs[i], vals[i]);
        end
        for (int i = 0; i < 5; i++) begin
            reg_read(offs[i], rdata);
            check_word($sformatf("wb_dat_o (offset %0d)", offs[i]), rdata, vals[i] & masks[i]);
        end
        enable_m = 1'b0;
        reg_write(REG_CTRL, '0);
        reg_read(REG_STATUS, rdata);
        check_word("wb_dat_o (status)", rdata, '0);
        page = 20'($urandom());
        while (page == PAGE_GID || page == PAGE_DMA) begin
            page = 20'($urandom());
        end
        bus_access({page, 10'($urandom())}, 1'b0, '0, rdata);
        check_word("wb_dat_o (unmapped page)", rdata, '0);
    endtask

    // tuser pixels while the DMA is disabled, always in whole pairs
    task automatic test_toggle_disabled();
        wb_data_t rdata;
        enable_m = 1'b0;
        reg_write(REG_CTRL, '0);
        repeat (3) begin
            send_pixel(rgb_t'({$urandom(), $urandom()}), 1'b1, 1'b0);
            send_pixel(rgb_t'({$urandom(), $urandom()}), 1'b0, 1'b0);
        end
        stream_idle();
        repeat (4) @(posedge axi4_mem_aclk);
        check_bit("frame_toggle_o", frame_toggle_o, toggle_m);
        reg_read(REG_STATUS, rdata);
        check_word("wb_dat_o (status)", rdata, '0);
    endtask

    task automatic run_frame();
        int         alen1;
        int         width;
        int         height;
        int         junk;
        addr_t      base;
        wb_data_t   rdata;
        alen1         = $urandom_range(1, 4);
        width         = 2 * alen1 * $urandom_range(1, 3);  // keeps beats a burst multiple
        height        = $urandom_range(1, 5);
        junk          = $urandom_range(0, 7);
        base          = addr_t'($urandom()) & ~addr_t'(BEAT_BYTES - 1);
        exp_awlen     = awlen_t'(alen1 - 1);
        frame_beats_m = width * height / 2;
        for (int k = 0; k < frame_beats_m / alen1; k++) begin
            exp_addrs.push_back(base + addr_t'(k * alen1 * BEAT_BYTES));
        end
        reg_write(REG_BASE, base);
        reg_write(REG_WIDTH, wb_data_t'(width));
        reg_write(REG_HEIGHT, wb_data_t'(height));
        reg_write(REG_AWLEN, wb_data_t'(exp_awlen));
        enable_m = 1'b1;
        reg_write(REG_CTRL, wb_data_t'(1));
        frames_m++;
        repeat (junk) begin
            send_pixel(rgb_t'({$urandom(), $urandom()}), 1'b0, 1'b0);
        end
        for (int i = 0; i < width * height; i++) begin
            send_pixel(rgb_t'({$urandom(), $urandom()}), i == 0, (i % width) == width - 1);
        end
        stream_idle();
        while (exp_beats.size() != 0 || exp_addrs.size() != 0) begin
            @(posedge axi4_mem_aclk);
        end
        rdata = '1;
        while (rdata[0]) begin              // wait for busy to clear
            reg_read(REG_STATUS, rdata);
        end
        check_word("wb_dat_o (status)", rdata, '0);
        reg_read(REG_FRAMES, rdata);
        check_word("wb_dat_o (frames)", rdata, wb_data_t'(frames_m));
        check_bit("frame_toggle_o", frame_toggle_o, toggle_m);
    endtask

    initial begin : stimulus
        wb_data_t rdata;
        rst_n_i    = 1'b0;
        wb_adr_i   = '0;
        wb_dat_i   = '0;
        wb_sel_i   = '0;
        wb_we_i    = 1'b0;
        wb_stb_i   = 1'b0;
        s_tuser_i  = 1'b0;
        s_tlast_i  = 1'b0;
        s_tvalid_i = 1'b0;
        s_tdata_i  = '0;
        enable_m      = 1'b0;
        toggle_m      = 1'b0;
        lo_m          = '0;
        lo_full_m     = 1'b0;
        lo_first_m    = 1'b0;
        frame_beats_m = 0;
        frame_left_m  = 0;
        frames_m      = 0;
        exp_awlen     = '0;
        pending_b     = 0;
        burst_beat    = 0;
        burst_open    = 1'b0;
        errors        = 0;
        void'($urandom(32'h1f29));
        repeat (10) @(posedge axi4_mem_aclk);
        #1;
        rst_n_i = 1'b1;

        @(negedge axi4_mem_aclk);
        check_bit("m_awvalid_o", m_awvalid_o, 1'b0);
        check_bit("m_wvalid_o", m_wvalid_o, 1'b0);
        check_bit("m_bready_o", m_bready_o, 1'b1);
        check_bit("frame_toggle_o", frame_toggle_o, 1'b0);
        for (int off = 0; off < 8; off++) begin
            reg_read(off, rdata);
            check_word($sformatf("wb_dat_o (offset %0d)", off), rdata, '0);
        end

        test_registers();
        test_toggle_disabled();
        repeat (NUM_FRAMES) begin
            run_frame();
        end

        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- test/video_capture_asserts.sv
// Protocol checks bound to the capture top level
// AXI4 AW and W valid must hold until ready, bus ack only with strobe
`timescale 1ns/100ps
`default_nettype none

module video_capture_asserts (
    input wire logic    axi4_mem_aclk,
    input wire logic    rst_n_i,
    input wire logic    m_awvalid_o,
    input wire logic    m_awready_i,
    input wire logic    m_wvalid_o,
    input wire logic    m_wready_i,
    input wire logic    wb_stb_i,
    input wire logic    wb_ack_o
);

    aw_hold: assert property (@(posedge axi4_mem_aclk) disable iff (!rst_n_i)
        m_awvalid_o && !m_awready_i |=> m_awvalid_o)
        else $error("m_awvalid_o dropped before m_awready_i");

    w_hold: assert property (@(posedge axi4_mem_aclk) disable iff (!rst_n_i)
        m_wvalid_o && !m_wready_i |=> m_wvalid_o)
        else $error("m_wvalid_o dropped before m_wready_i");

    ack_needs_stb: assert property (@(posedge axi4_mem_aclk) disable iff (!rst_n_i)
        wb_ack_o |-> wb_stb_i)
        else $error("wb_ack_o high without wb_stb_i");

endmodule

bind video_capture_top video_capture_asserts u_asserts (.*);

`default_nettype wire
